/* Makefile */
# Verilator build and run of the NIC control plane testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = nic_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+hdl
hdl/nic_pkg.sv
hdl/conn_setup_if.sv
hdl/nic_csr.sv
hdl/conn_manager.sv
hdl/pkt_counters.sv
hdl/nic_top.sv
testbench/nic_checker.sv
testbench/nic_tb.sv

/* hdl/conn_manager.sv */
// =========================================================================
// Connection setup engine. Owns the open-slot table, clears it one slot
// per cycle after init, and serves open/close frames over the four-phase
// handshake. Frame latency varies with the low bits of the slot id.
// =========================================================================

`include "nic_cfg.svh"

module conn_manager
    import nic_pkg::*;
(
    input  logic          ccip_clk,
    input  logic          reset,
    input  logic          init,
    output logic          initialized,
    conn_setup_if.engine  conn
);

    localparam int num_conns = 1 << `NIC_LOG_CONNS;

    conn_state_e               state;
    logic [num_conns-1:0]      open_tbl;
    logic [`NIC_LOG_CONNS-1:0] sweep_idx;
    logic [1:0]                latency;
    logic                      slot_open;
    logic                      op_ok;

    // Frame is stable for as long as req is high
    assign slot_open = open_tbl[conn.frame.conn_id];
    assign op_ok     = (conn.frame.op == conn_open) ? !slot_open : slot_open;

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            state       <= idle;
            initialized <= 1'b0;
            sweep_idx   <= '0;
            latency     <= '0;
            conn.ack    <= 1'b0;
        end else if (init) begin
            // Restart the sweep, any frame in flight is served afterwards
            state       <= init_sweep;
            initialized <= 1'b0;
            sweep_idx   <= '0;
            conn.ack    <= 1'b0;
        end else begin
            case (state)
                init_sweep: begin
                    open_tbl[sweep_idx] <= 1'b0;
                    sweep_idx <= sweep_idx + 1'b1;
                    if (sweep_idx == '1) begin
                        initialized <= 1'b1;
                        state       <= idle;
                    end
                end

                idle: begin
                    if (initialized && conn.req) begin
                        latency <= conn.frame.conn_id[1:0];
                        state   <= busy;
                    end
                end

                busy: begin
                    if (latency != '0) begin
                        latency <= latency - 1'b1;
                    end else begin
                        // Success flips the slot, failure leaves it alone
                        if (op_ok) begin
                            open_tbl[conn.frame.conn_id] <= !slot_open;
                        end
                        conn.result <= '{valid: 1'b1,
                                         success: op_ok,
                                         conn_id: conn.frame.conn_id};
                        conn.ack <= 1'b1;
                        state    <= done;
                    end
                end

                done: begin
                    // Hold ack until the requester lets go
                    if (!conn.req) begin
                        conn.ack <= 1'b0;
                        state    <= idle;
                    end
                end

                default: state <= idle;
            endcase
        end
    end

endmodule

/* hdl/conn_setup_if.sv */
// =========================================================================
// Four-phase req/ack channel that carries a setup frame from the CSR
// block to the connection engine and the result back.
// =========================================================================

interface conn_setup_if
    import nic_pkg::*;
();

    logic         req;
    conn_frame_t  frame;
    logic         ack;
    conn_status_t result;

    // Requester side
    modport csr (
        output req,
        output frame,
        input  ack,
        input  result
    );

    // Responder side
    modport engine (
        input  req,
        input  frame,
        output ack,
        output result
    );

endinterface

/* hdl/nic_cfg.svh */
// =========================================================================
// Build-time constants of the NIC control plane: bus widths, identity
// values, the MMIO register map, connection table size and counter width.
// Included by the package and by every module that uses one of them.
// =========================================================================

`ifndef NIC_CFG_SVH
`define NIC_CFG_SVH

// MMIO bus widths
`define NIC_MMIO_ADDR_WIDTH 16
`define NIC_MMIO_DATA_WIDTH 64
`define NIC_TID_WIDTH       9

// Identity reported through status and the id words
`define NIC_ID       8'h2a
`define NIC_AFU_ID_L 64'h9d3b_61c7_45f0_a2e8
`define NIC_AFU_ID_H 64'h5c1e_0f84_b7d2_3a69

// Feature header and accelerator id, word addresses
`define NIC_ADDR_DFH      16'h0000
`define NIC_ADDR_AFU_ID_L 16'h0002
`define NIC_ADDR_AFU_ID_H 16'h0004

// NIC registers, 64-bit objects on even addresses
`define NIC_CSR_BASE         16'h0020
`define NIC_ADDR_START       (`NIC_CSR_BASE + 16'd4)
`define NIC_ADDR_INIT        (`NIC_CSR_BASE + 16'd8)
`define NIC_ADDR_STATUS      (`NIC_CSR_BASE + 16'd10)
`define NIC_ADDR_CNT_SEL     (`NIC_CSR_BASE + 16'd14)
`define NIC_ADDR_CNT_VAL     (`NIC_CSR_BASE + 16'd16)
`define NIC_ADDR_CONN_SETUP  (`NIC_CSR_BASE + 16'd30)
`define NIC_ADDR_CONN_STATUS (`NIC_CSR_BASE + 16'd32)

// Connection table, 2**4 = 16 slots
`define NIC_LOG_CONNS 4

// Packet counters
`define NIC_CNT_WIDTH 32

`endif

/* hdl/nic_csr.sv */
// =========================================================================
// MMIO register block. Decodes host writes into control registers, issues
// the init pulse and setup requests, and answers every read one cycle
// later with the tid echoed. Connection status clears when read.
// =========================================================================

`include "nic_cfg.svh"

module nic_csr
    import nic_pkg::*;
(
    input  logic                            ccip_clk,
    input  logic                            reset,

    input  logic                            mmio_wr_valid,
    input  logic                            mmio_rd_valid,
    input  logic [`NIC_MMIO_ADDR_WIDTH-1:0] mmio_addr,
    input  logic [`NIC_MMIO_DATA_WIDTH-1:0] mmio_wr_data,
    input  logic [`NIC_TID_WIDTH-1:0]       mmio_tid,

    output logic                            mmio_rd_data_valid,
    output logic [`NIC_MMIO_DATA_WIDTH-1:0] mmio_rd_data,
    output logic [`NIC_TID_WIDTH-1:0]       mmio_rd_tid,

    input  logic                            initialized,
    input  logic [`NIC_CNT_WIDTH-1:0]       cnt_value,
    output logic                            init,
    output cnt_sel_e                        cnt_sel,

    conn_setup_if.csr                       conn
);

    // AFU feature type in 63:60 and end of feature list at bit 40
    localparam logic [`NIC_MMIO_DATA_WIDTH-1:0] dfh_word = {4'h1, 19'h0, 1'b1, 40'h0};

    logic                            start;
    nic_status_t                     status;
    conn_status_t                    conn_status;
    logic [`NIC_MMIO_DATA_WIDTH-1:0] rd_word;

    logic wr_start;
    logic wr_init;
    logic wr_cnt_sel;
    logic wr_setup;
    logic setup_accept;
    logic rd_conn_status;
    logic setup_done;

    // =========================================================================
    // Write decode
    // =========================================================================
    assign wr_start   = mmio_wr_valid && (mmio_addr == `NIC_ADDR_START);
    assign wr_init    = mmio_wr_valid && (mmio_addr == `NIC_ADDR_INIT);
    assign wr_cnt_sel = mmio_wr_valid && (mmio_addr == `NIC_ADDR_CNT_SEL);
    assign wr_setup   = mmio_wr_valid && (mmio_addr == `NIC_ADDR_CONN_SETUP);

    // Setup writes are dropped while a handshake is still open
    assign setup_accept = wr_setup && !conn.req && !conn.ack;
    assign setup_done   = conn.req && conn.ack;

    assign rd_conn_status = mmio_rd_valid && (mmio_addr == `NIC_ADDR_CONN_STATUS);

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            start   <= 1'b0;
            init    <= 1'b0;
            cnt_sel <= cnt_rx;
        end else begin
            // One-cycle pulse per INIT write
            init <= wr_init;
            if (wr_start) begin
                start <= mmio_wr_data[0];
            end
            if (wr_cnt_sel) begin
                cnt_sel <= cnt_sel_e'(mmio_wr_data[1:0]);
            end
        end
    end

    // =========================================================================
    // Connection setup handshake
    // =========================================================================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            conn.req <= 1'b0;
        end else if (setup_accept) begin
            conn.req <= 1'b1;
        end else if (setup_done) begin
            conn.req <= 1'b0;
        end
    end

    // Frame held until the next accepted write
    always_ff @(posedge ccip_clk) begin
        if (setup_accept) begin
            conn.frame <= conn_frame_t'(mmio_wr_data[$bits(conn_frame_t)-1:0]);
        end
    end

    // A new result wins over a clear in the same cycle
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            conn_status <= '0;
        end else if (setup_done) begin
            conn_status <= conn.result;
        end else if (rd_conn_status) begin
            conn_status <= '0;
        end
    end

    // =========================================================================
    // Status word
    // =========================================================================
    always_ff @(posedge ccip_clk) begin
        status.nic_id <= `NIC_ID;
        if (reset) begin
            status.ready   <= 1'b0;
            status.running <= 1'b0;
        end else begin
            status.ready   <= initialized;
            status.running <= initialized && start;
        end
    end

    // =========================================================================
    // Read path
    // =========================================================================
    always_comb begin
        rd_word = '0;
        case (mmio_addr)
            `NIC_ADDR_DFH:         rd_word = dfh_word;
            `NIC_ADDR_AFU_ID_L:    rd_word = `NIC_AFU_ID_L;
            `NIC_ADDR_AFU_ID_H:    rd_word = `NIC_AFU_ID_H;
            `NIC_ADDR_STATUS:      rd_word[$bits(nic_status_t)-1:0] = status;
            `NIC_ADDR_CNT_VAL:     rd_word[`NIC_CNT_WIDTH-1:0] = cnt_value;
            `NIC_ADDR_CONN_STATUS: rd_word[$bits(conn_status_t)-1:0] = conn_status;
            default:               rd_word = '0;
        endcase
    end

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            mmio_rd_data_valid <= 1'b0;
        end else begin
            mmio_rd_data_valid <= mmio_rd_valid;
        end
    end

    always_ff @(posedge ccip_clk) begin
        if (mmio_rd_valid) begin
            mmio_rd_data <= rd_word;
            mmio_rd_tid  <= mmio_tid;
        end
    end

endmodule

/* hdl/nic_pkg.sv */
// =========================================================================
// Types shared by the NIC control plane RTL and its testbench: setup
// opcodes, setup frame and result, the status word and the FSM states.
// =========================================================================

`include "nic_cfg.svh"

package nic_pkg;

    // Connection setup opcode
    typedef enum logic {
        conn_open  = 1'b0,
        conn_close = 1'b1
    } conn_op_e;

    // Setup frame as written through MMIO, op in bit 4
    typedef struct packed {
        conn_op_e                  op;
        logic [`NIC_LOG_CONNS-1:0] conn_id;
    } conn_frame_t;

    // Setup result, valid in bit 5 and success in bit 4
    typedef struct packed {
        logic                      valid;
        logic                      success;
        logic [`NIC_LOG_CONNS-1:0] conn_id;
    } conn_status_t;

    // Status word
    typedef struct packed {
        logic       running;
        logic       ready;
        logic [7:0] nic_id;
    } nic_status_t;

    // Counter selector
    typedef enum logic [1:0] {
        cnt_rx   = 2'd0,
        cnt_tx   = 2'd1,
        cnt_drop = 2'd2
    } cnt_sel_e;

    // Connection engine FSM
    typedef enum logic [1:0] {
        init_sweep,
        idle,
        busy,
        done
    } conn_state_e;

endpackage

/* hdl/nic_top.sv */
// =========================================================================
// NIC control plane top level. Connects the MMIO CSR block, the
// connection setup engine and the packet counters; all ports are plain.
// =========================================================================

`include "nic_cfg.svh"

module nic_top
    import nic_pkg::*;
(
    input  logic                            ccip_clk,
    input  logic                            reset,

    // MMIO request
    input  logic                            mmio_wr_valid,
    input  logic                            mmio_rd_valid,
    input  logic [`NIC_MMIO_ADDR_WIDTH-1:0] mmio_addr,
    input  logic [`NIC_MMIO_DATA_WIDTH-1:0] mmio_wr_data,
    input  logic [`NIC_TID_WIDTH-1:0]       mmio_tid,

    // MMIO read response
    output logic                            mmio_rd_data_valid,
    output logic [`NIC_MMIO_DATA_WIDTH-1:0] mmio_rd_data,
    output logic [`NIC_TID_WIDTH-1:0]       mmio_rd_tid,

    // Packet event strobes
    input  logic                            rx_req_valid,
    input  logic                            tx_resp_valid,
    input  logic                            tx_drop_valid
);

    logic                      init;
    logic                      initialized;
    cnt_sel_e                  cnt_sel;
    logic [`NIC_CNT_WIDTH-1:0] cnt_value;

    conn_setup_if conn_if ();

    nic_csr nic_csr_inst (
        .ccip_clk           (ccip_clk),
        .reset              (reset),
        .mmio_wr_valid      (mmio_wr_valid),
        .mmio_rd_valid      (mmio_rd_valid),
        .mmio_addr          (mmio_addr),
        .mmio_wr_data       (mmio_wr_data),
        .mmio_tid           (mmio_tid),
        .mmio_rd_data_valid (mmio_rd_data_valid),
        .mmio_rd_data       (mmio_rd_data),
        .mmio_rd_tid        (mmio_rd_tid),
        .initialized        (initialized),
        .cnt_value          (cnt_value),
        .init               (init),
        .cnt_sel            (cnt_sel),
        .conn               (conn_if.csr)
    );

    conn_manager conn_manager_inst (
        .ccip_clk    (ccip_clk),
        .reset       (reset),
        .init        (init),
        .initialized (initialized),
        .conn        (conn_if.engine)
    );

    pkt_counters pkt_counters_inst (
        .ccip_clk      (ccip_clk),
        .reset         (reset),
        .init          (init),
        .rx_req_valid  (rx_req_valid),
        .tx_resp_valid (tx_resp_valid),
        .tx_drop_valid (tx_drop_valid),
        .cnt_sel       (cnt_sel),
        .cnt_value     (cnt_value)
    );

endmodule

/* hdl/pkt_counters.sv */
// =========================================================================
// Packet event counters. One wrapping counter per strobe, cleared on
// reset or init; the selected one is registered onto cnt_value.
// =========================================================================

`include "nic_cfg.svh"

module pkt_counters
    import nic_pkg::*;
(
    input  logic                      ccip_clk,
    input  logic                      reset,
    input  logic                      init,
    input  logic                      rx_req_valid,
    input  logic                      tx_resp_valid,
    input  logic                      tx_drop_valid,
    input  cnt_sel_e                  cnt_sel,
    output logic [`NIC_CNT_WIDTH-1:0] cnt_value
);

    localparam int num_cnts = 3;

    logic [num_cnts-1:0]       events;
    logic [`NIC_CNT_WIDTH-1:0] cnt [num_cnts];

    // Index order follows cnt_sel_e
    assign events = {tx_drop_valid, tx_resp_valid, rx_req_valid};

    always_ff @(posedge ccip_clk) begin
        if (reset || init) begin
            for (int i = 0; i < num_cnts; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_cnts; i++) begin
                if (events[i]) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    // Selected counter, one cycle behind
    always_ff @(posedge ccip_clk) begin
        case (cnt_sel)
            cnt_rx:   cnt_value <= cnt[0];
            cnt_tx:   cnt_value <= cnt[1];
            cnt_drop: cnt_value <= cnt[2];
            default:  cnt_value <= '0;
        endcase
    end

endmodule

/* testbench/nic_checker.sv */
// =========================================================================
// Protocol checks bound into the NIC top level: read response timing and
// the four-phase setup handshake between CSR block and connection engine.
// =========================================================================

module nic_checker
    import nic_pkg::*;
(
    input logic        ccip_clk,
    input logic        reset,
    input logic        mmio_rd_valid,
    input logic        mmio_rd_data_valid,
    input logic        req,
    input logic        ack,
    input conn_frame_t frame
);

    // Read response exactly one cycle after the request
    rd_resp_follows: assert property (@(posedge ccip_clk) disable iff (reset)
        mmio_rd_valid |=> mmio_rd_data_valid)
        else $error("read response missing one cycle after a read request");

    rd_resp_only_after_req: assert property (@(posedge ccip_clk) disable iff (reset)
        !mmio_rd_valid |=> !mmio_rd_data_valid)
        else $error("read response without a read request");

    // Frame held while the request is open
    frame_stable: assert property (@(posedge ccip_clk) disable iff (reset)
        (req && $past(req)) |-> $stable(frame))
        else $error("setup frame changed while req was high");

    ack_needs_req: assert property (@(posedge ccip_clk) disable iff (reset)
        $rose(ack) |-> req)
        else $error("ack rose without req");

    req_waits_for_ack_low: assert property (@(posedge ccip_clk) disable iff (reset)
        $rose(req) |-> !ack)
        else $error("req rose while ack was still high");

endmodule

/* testbench/nic_tb.sv */
// =========================================================================
// Testbench for the NIC control plane. Runs a table of MMIO writes, reads,
// event bursts and idle gaps against nic_top and checks every response.
// =========================================================================

`include "nic_cfg.svh"

module nic_tb
    import nic_pkg::*;
();

    typedef enum {
        step_wr,
        step_rd_data,
        step_rd_status,
        step_rd_conn,
        step_poll_conn,
        step_burst,
        step_wait
    } step_kind_e;

    logic                            ccip_clk = 1'b0;
    logic                            reset;
    logic                            mmio_wr_valid;
    logic                            mmio_rd_valid;
    logic [`NIC_MMIO_ADDR_WIDTH-1:0] mmio_addr;
    logic [`NIC_MMIO_DATA_WIDTH-1:0] mmio_wr_data;
    logic [`NIC_TID_WIDTH-1:0]       mmio_tid;
    logic                            mmio_rd_data_valid;
    logic [`NIC_MMIO_DATA_WIDTH-1:0] mmio_rd_data;
    logic [`NIC_TID_WIDTH-1:0]       mmio_rd_tid;
    logic                            rx_req_valid;
    logic                            tx_resp_valid;
    logic                            tx_drop_valid;

    // Step table with one entry per index across the queues
    step_kind_e                      kinds [$];
    string                           names [$];
    logic [`NIC_MMIO_ADDR_WIDTH-1:0] addrs [$];
    logic [63:0]                     values [$];
    logic [63:0]                     masks [$];

    integer                    seed;
    logic [`NIC_TID_WIDTH-1:0] next_tid;
    int                        cycles = 0;
    int                        limit = 0;

    nic_top nic_top_inst (
        .ccip_clk           (ccip_clk),
        .reset              (reset),
        .mmio_wr_valid      (mmio_wr_valid),
        .mmio_rd_valid      (mmio_rd_valid),
        .mmio_addr          (mmio_addr),
        .mmio_wr_data       (mmio_wr_data),
        .mmio_tid           (mmio_tid),
        .mmio_rd_data_valid (mmio_rd_data_valid),
        .mmio_rd_data       (mmio_rd_data),
        .mmio_rd_tid        (mmio_rd_tid),
        .rx_req_valid       (rx_req_valid),
        .tx_resp_valid      (tx_resp_valid),
        .tx_drop_valid      (tx_drop_valid)
    );

    bind nic_top nic_checker nic_checker_inst (
        .ccip_clk           (ccip_clk),
        .reset              (reset),
        .mmio_rd_valid      (mmio_rd_valid),
        .mmio_rd_data_valid (mmio_rd_data_valid),
        .req                (conn_if.req),
        .ack                (conn_if.ack),
        .frame              (conn_if.frame)
    );

    always #4 ccip_clk = ~ccip_clk;

    // =========================================================================
    // Failure reporting and compare tasks
    // =========================================================================
    task automatic fail_run(input string what);
        $display("Test failed");
        $fatal(1, "%s", what);
    endtask

    task automatic compare_data(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            fail_run("data mismatch");
        end
    endtask

    task automatic compare_status(input string name, input nic_status_t exp,
                                  input nic_status_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            fail_run("status mismatch");
        end
    endtask

    task automatic compare_conn(input string name, input conn_status_t exp,
                                input conn_status_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            fail_run("connection status mismatch");
        end
    endtask

    task automatic compare_tid(input string name, input logic [`NIC_TID_WIDTH-1:0] exp,
                               input logic [`NIC_TID_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s tid: expected %h, actual %h", name, exp, act);
            fail_run("tid mismatch");
        end
    endtask

    // =========================================================================
    // Bus and strobe drivers that start 1 unit after a rising edge
    // =========================================================================
    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge ccip_clk);
            #1;
        end
    endtask

    task automatic mmio_write(input logic [`NIC_MMIO_ADDR_WIDTH-1:0] addr,
                              input logic [63:0] data);
        mmio_wr_valid = 1'b1;
        mmio_addr     = addr;
        mmio_wr_data  = data;
        idle_cycles(1);
        mmio_wr_valid = 1'b0;
    endtask

    task automatic mmio_read(input string name, input logic [`NIC_MMIO_ADDR_WIDTH-1:0] addr,
                             output logic [63:0] data);
        logic [`NIC_TID_WIDTH-1:0] tid;
        tid           = next_tid;
        next_tid      = next_tid + 1'b1;
        mmio_rd_valid = 1'b1;
        mmio_addr     = addr;
        mmio_tid      = tid;
        idle_cycles(1);
        mmio_rd_valid = 1'b0;
        while (!mmio_rd_data_valid) begin
            idle_cycles(1);
        end
        compare_tid(name, tid, mmio_rd_tid);
        data = mmio_rd_data;
    endtask

    // Read connection status until a result shows up
    task automatic poll_conn(input string name, output logic [63:0] data);
        mmio_read(name, `NIC_ADDR_CONN_STATUS, data);
        while (!data[$bits(conn_status_t)-1]) begin
            mmio_read(name, `NIC_ADDR_CONN_STATUS, data);
        end
    endtask

    task automatic strobe_burst(input cnt_sel_e which, input int count);
        int gap;
        for (int n = 0; n < count; n++) begin
            rx_req_valid  = (which == cnt_rx);
            tx_resp_valid = (which == cnt_tx);
            tx_drop_valid = (which == cnt_drop);
            idle_cycles(1);
            rx_req_valid  = 1'b0;
            tx_resp_valid = 1'b0;
            tx_drop_valid = 1'b0;
            gap = $random(seed) & 3;
            idle_cycles(gap);
        end
    endtask

    // =========================================================================
    // Expected words laid out by the register map
    // =========================================================================
    function automatic logic [63:0] status_exp(input logic ready, input logic running);
        nic_status_t s;
        s = '{running: running, ready: ready, nic_id: `NIC_ID};
        return 64'(s);
    endfunction

    function automatic logic [63:0] conn_exp(input logic success, input int id);
        conn_status_t c;
        c = '{valid: 1'b1, success: success, conn_id: id[`NIC_LOG_CONNS-1:0]};
        return 64'(c);
    endfunction

    function automatic logic [63:0] frame_data(input conn_op_e op, input int id);
        conn_frame_t f;
        f = '{op: op, conn_id: id[`NIC_LOG_CONNS-1:0]};
        return 64'(f);
    endfunction

    function automatic int step_cost(input step_kind_e kind, input logic [63:0] value);
        case (kind)
            step_wr:        return 1;
            step_burst:     return 4 * int'(value);
            step_wait:      return int'(value);
            step_poll_conn: return 40;
            default:        return 2;
        endcase
    endfunction

    // =========================================================================
    // Step table
    // =========================================================================
    task automatic add_step(input step_kind_e kind, input string name,
                            input logic [`NIC_MMIO_ADDR_WIDTH-1:0] addr,
                            input logic [63:0] value, input logic [63:0] mask = '1);
        kinds.push_back(kind);
        names.push_back(name);
        addrs.push_back(addr);
        values.push_back(value);
        masks.push_back(mask);
    endtask

    // Setup write followed by a poll for its result and a check of the clear on read
    task automatic add_setup(input string name, input conn_op_e op, input int id,
                             input logic success);
        add_step(step_wr, name, `NIC_ADDR_CONN_SETUP, frame_data(op, id));
        add_step(step_poll_conn, name, `NIC_ADDR_CONN_STATUS, conn_exp(success, id));
        add_step(step_rd_conn, {name, " cleared"}, `NIC_ADDR_CONN_STATUS, 64'd0);
    endtask

    task automatic add_count_check(input string name, input cnt_sel_e sel, input int count);
        add_step(step_wr, name, `NIC_ADDR_CNT_SEL, 64'(sel));
        add_step(step_wait, name, 16'd0, 64'd2);
        add_step(step_rd_data, name, `NIC_ADDR_CNT_VAL, 64'(count));
    endtask

    task automatic build_table();
        // Identification and reset state
        add_step(step_rd_data, "dfh", `NIC_ADDR_DFH, 64'h1000_0100_0000_0000,
                 64'hf000_0100_0000_0000);
        add_step(step_rd_data, "afu id low", `NIC_ADDR_AFU_ID_L, `NIC_AFU_ID_L);
        add_step(step_rd_data, "afu id high", `NIC_ADDR_AFU_ID_H, `NIC_AFU_ID_H);
        add_step(step_rd_status, "status after reset", `NIC_ADDR_STATUS, status_exp(0, 0));
        add_step(step_rd_data, "counter after reset", `NIC_ADDR_CNT_VAL, 64'd0);
        add_step(step_rd_conn, "conn after reset", `NIC_ADDR_CONN_STATUS, 64'd0);

        // Init, start and unmapped space
        add_step(step_wr, "init", `NIC_ADDR_INIT, 64'd1);
        add_step(step_wait, "init sweep", 16'd0, 64'd20);
        add_step(step_rd_status, "ready after init", `NIC_ADDR_STATUS, status_exp(1, 0));
        add_step(step_wr, "start", `NIC_ADDR_START, 64'd1);
        add_step(step_wait, "start settle", 16'd0, 64'd2);
        add_step(step_rd_status, "running after start", `NIC_ADDR_STATUS, status_exp(1, 1));
        add_step(step_rd_data, "unmapped low", 16'h0010, 64'd0);
        add_step(step_rd_data, "unmapped high", 16'h7ffe, 64'd0);

        // Packet counters
        add_step(step_burst, "rx burst", 16'(cnt_rx), 64'd9);
        add_step(step_burst, "tx burst", 16'(cnt_tx), 64'd6);
        add_step(step_burst, "drop burst", 16'(cnt_drop), 64'd4);
        add_step(step_wait, "burst settle", 16'd0, 64'd3);
        add_count_check("rx count", cnt_rx, 9);
        add_count_check("tx count", cnt_tx, 6);
        add_count_check("drop count", cnt_drop, 4);
        // Selector value 3 has no counter behind it
        add_step(step_wr, "undefined selector", `NIC_ADDR_CNT_SEL, 64'd3);
        add_step(step_wait, "undefined selector", 16'd0, 64'd2);
        add_step(step_rd_data, "undefined selector", `NIC_ADDR_CNT_VAL, 64'd0);
        add_step(step_wr, "init clears counters", `NIC_ADDR_INIT, 64'd1);
        add_step(step_wait, "init sweep", 16'd0, 64'd20);
        add_count_check("rx after init", cnt_rx, 0);
        add_count_check("tx after init", cnt_tx, 0);
        add_count_check("drop after init", cnt_drop, 0);

        // Open and close rules
        add_setup("open closed slot", conn_open, 9, 1'b1);
        add_setup("open open slot", conn_open, 9, 1'b0);
        add_setup("close open slot", conn_close, 9, 1'b1);
        add_setup("close closed slot", conn_close, 9, 1'b0);
        add_setup("open slot 14", conn_open, 14, 1'b1);
        add_setup("open slot 3", conn_open, 3, 1'b1);

        // Setup during the sweep with a second write dropped by back-pressure
        add_step(step_wr, "init with setup", `NIC_ADDR_INIT, 64'd1);
        add_step(step_wr, "open during sweep", `NIC_ADDR_CONN_SETUP,
                 frame_data(conn_open, 5));
        add_step(step_wr, "close while busy", `NIC_ADDR_CONN_SETUP,
                 frame_data(conn_close, 5));
        add_step(step_rd_conn, "no result during sweep", `NIC_ADDR_CONN_STATUS, 64'd0);
        add_step(step_poll_conn, "open during sweep", `NIC_ADDR_CONN_STATUS,
                 conn_exp(1'b1, 5));
        add_step(step_rd_conn, "open during sweep cleared", `NIC_ADDR_CONN_STATUS, 64'd0);
        add_step(step_rd_status, "ready after sweep", `NIC_ADDR_STATUS, status_exp(1, 1));
        add_setup("slot 5 left open", conn_close, 5, 1'b1);
        add_setup("sweep cleared slot 14", conn_open, 14, 1'b1);
    endtask

    task automatic run_step(input int i);
        logic [63:0] data;
        case (kinds[i])
            step_wr: mmio_write(addrs[i], values[i]);
            step_rd_data: begin
                mmio_read(names[i], addrs[i], data);
                compare_data(names[i], values[i], data & masks[i]);
            end
            step_rd_status: begin
                mmio_read(names[i], addrs[i], data);
                compare_status(names[i], nic_status_t'(values[i][$bits(nic_status_t)-1:0]),
                               nic_status_t'(data[$bits(nic_status_t)-1:0]));
            end
            step_rd_conn: begin
                mmio_read(names[i], addrs[i], data);
                compare_conn(names[i], conn_status_t'(values[i][$bits(conn_status_t)-1:0]),
                             conn_status_t'(data[$bits(conn_status_t)-1:0]));
            end
            step_poll_conn: begin
                poll_conn(names[i], data);
                compare_conn(names[i], conn_status_t'(values[i][$bits(conn_status_t)-1:0]),
                             conn_status_t'(data[$bits(conn_status_t)-1:0]));
            end
            step_burst: strobe_burst(cnt_sel_e'(addrs[i][1:0]), int'(values[i]));
            default: idle_cycles(int'(values[i]));
        endcase
    endtask

    // =========================================================================
    // Timeout and main sequence
    // =========================================================================
    always @(posedge ccip_clk) begin
        if (!reset) begin
            cycles <= cycles + 1;
            if (cycles > limit) begin
                fail_run("run exceeded its cycle budget, DUT stopped responding");
            end
        end
    end

    initial begin
        reset         = 1'b1;
        mmio_wr_valid = 1'b0;
        mmio_rd_valid = 1'b0;
        mmio_addr     = '0;
        mmio_wr_data  = '0;
        mmio_tid      = '0;
        rx_req_valid  = 1'b0;
        tx_resp_valid = 1'b0;
        tx_drop_valid = 1'b0;
        seed          = 32'hce7c_a784;
        next_tid      = 9'h1a5;

        build_table();
        foreach (kinds[i]) begin
            limit += step_cost(kinds[i], values[i]);
        end
        limit = 4 * limit;

        idle_cycles(16);
        reset = 1'b0;

        foreach (kinds[i]) begin
            run_step(i);
        end

        $display("Test passed");
        $finish;
    end

endmodule
